// File: all.f
verilog/rp_pkg.sv
verilog/sys_bus_decoder.sv
verilog/housekeeping.sv
verilog/adc_frontend.sv
verilog/dc_generator.sv
verilog/p_controller.sv
verilog/dac_backend.sv
verilog/rp_top.sv
testbench/tb_rp_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -f all.f --top-module tb_rp_top -o tb_rp_top
output="$(./obj_dir/tb_rp_top)"
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// File: testbench/tb_rp_top.sv
// drives rp_top at its default KP_SHIFT with seed 81; expects full-word bus writes and 16 settling cycles per check
`timescale 1ns/1ps

module tb_rp_top;

  localparam int NUM_TESTS = 6;
  localparam int CLK_NS    = 100;
  localparam int ACK_LIMIT = 8;           // cycles to wait for ack
  localparam int SETTLE    = 16;

  logic              adc_clk = 1'b0;
  logic              rst_i;
  rp_pkg::adc_code_t adc_dat_a_i;
  rp_pkg::adc_code_t adc_dat_b_i;
  rp_pkg::bus_addr_t sys_addr_i;
  rp_pkg::bus_data_t sys_wdata_i;
  logic              sys_wen_i;
  logic              sys_ren_i;
  rp_pkg::bus_data_t sys_rdata_o;
  logic              sys_ack_o;
  logic              sys_err_o;
  rp_pkg::adc_code_t dac_a_o;
  rp_pkg::adc_code_t dac_b_o;
  logic [7:0]        led_o;

  integer seed        = 81;
  int     errors      = 0;
  int     checks      = 0;
  int     errs_before = 0;             // error count when the test began

  // register model
  int sp_m  [2];
  int kp_m  [2];
  int lvl_m [2];
  int pin_m [2];                        // raw pin codes
  int en_m;
  int led_m;

  always #(CLK_NS / 2) adc_clk = ~adc_clk;

  rp_top dut0 (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o),
    .led_o       (led_o)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic int sext(input int v, input int bits);
    return (v <<< (32 - bits)) >>> (32 - bits);
  endfunction

  // negative slope, code 0 is +full scale
  function automatic int to_sample(input int code);
    return 8191 - code;
  endfunction

  function automatic int to_code(input int s);
    return 8191 - s;
  endfunction

  function automatic int clamp(input int v);
    if (v > 8191)
      return 8191;
    if (v < -8192)
      return -8192;
    return v;
  endfunction

  function automatic int ctrl_out(input int sp, input int din, input int kp);
    int p;
    p = (sp - din) * kp;                // fits easily in 32 bits
    return clamp(p >>> dut0.KP_SHIFT);  // shift as built into dut0
  endfunction

  function automatic int expected_dac(input int ch);
    int gen_v;
    gen_v = (((en_m >> ch) & 1) != 0) ? lvl_m[ch] : 0;
    return to_code(clamp(gen_v + ctrl_out(sp_m[ch], to_sample(pin_m[ch]), kp_m[ch])));
  endfunction

  function automatic logic [31:0] addr_of(input int region, input rp_pkg::reg_off_t off);
    return {9'b0, 3'(region), off};     // region in bits 22..20
  endfunction

  ////////////////////////////////////////////////////////////
  // bus and helper tasks
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // one-cycle strobe, then wait for ack; caller sits 1 ns after an edge
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic is_write, output logic [31:0] rdata, output logic err);
    int n;
    n           = 0;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = is_write;
    sys_ren_i   = ~is_write;
    @(posedge adc_clk);
    #1;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    while (!sys_ack_o && n < ACK_LIMIT)
    begin
      @(posedge adc_clk);
      #1;
      n++;
    end
    if (!sys_ack_o)
    begin
      errors++;
      $display("bus access to address %h was never acknowledged", addr);
    end
    rdata = sys_rdata_o;                // valid with ack
    err   = sys_err_o;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        er;
    bus_access(addr, data, 1'b1, rd, er);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic err);
    bus_access(addr, 32'h0, 1'b0, rdata, err);
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] expected);
    logic [31:0] rd;
    logic        er;
    bus_read(addr, rd, er);
    check(name, expected, rd);
    check({name, "_err"}, 32'h0, 32'(er));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
    #1;
  endtask

  task automatic set_enable(input int v);
    bus_write(addr_of(rp_pkg::REGION_GEN, rp_pkg::GEN_EN_ADDR), v);
    en_m = v & 'h3;
  endtask

  task automatic set_level(input int ch, input int v);
    bus_write(addr_of(rp_pkg::REGION_GEN,
              (ch == 0) ? rp_pkg::GEN_LVL_A_ADDR : rp_pkg::GEN_LVL_B_ADDR), v);
    lvl_m[ch] = sext(v & 'h3FFF, 14);
  endtask

  task automatic set_sp(input int ch, input int v);
    bus_write(addr_of(rp_pkg::REGION_PID,
              (ch == 0) ? rp_pkg::PID_SP_A_ADDR : rp_pkg::PID_SP_B_ADDR), v);
    sp_m[ch] = sext(v & 'h3FFF, 14);
  endtask

  task automatic set_kp(input int ch, input int v);
    bus_write(addr_of(rp_pkg::REGION_PID,
              (ch == 0) ? rp_pkg::PID_KP_A_ADDR : rp_pkg::PID_KP_B_ADDR), v);
    kp_m[ch] = sext(v & 'hFFF, 12);
  endtask

  task automatic set_pins(input int a, input int b);
    pin_m[0]    = a & 'h3FFF;
    pin_m[1]    = b & 'h3FFF;
    adc_dat_a_i = rp_pkg::adc_code_t'(pin_m[0]);
    adc_dat_b_i = rp_pkg::adc_code_t'(pin_m[1]);
  endtask

  task automatic clear_regs();
    set_enable(0);
    for (int ch = 0; ch < 2; ch++)
    begin
      set_level(ch, 0);
      set_sp(ch, 0);
      set_kp(ch, 0);
    end
  endtask

  task automatic check_dacs(input string name);
    check({name, "_a"}, expected_dac(0), 32'(dac_a_o));
    check({name, "_b"}, expected_dac(1), 32'(dac_b_o));
  endtask

  task automatic finish_test(input string name);
    $display("test %0s finished with %0d errors", name, errors - errs_before);
    errs_before = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rd;
    logic        er;
    int          v;
    int          mag;
    int          gs;
    int          ps;
    int          mode;
    rst_i       = 1'b1;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    en_m        = 0;
    led_m       = 0;
    for (int ch = 0; ch < 2; ch++)
    begin
      sp_m[ch]  = 0;
      kp_m[ch]  = 0;
      lvl_m[ch] = 0;
    end
    set_pins('h1FFF, 'h1FFF);           // zero sample
    repeat (5) @(posedge adc_clk);
    #1;
    rst_i = 1'b0;
    wait_cycles(2);

    // reset values
    check("reset_dac_a", 32'h1FFF, 32'(dac_a_o));
    check("reset_dac_b", 32'h1FFF, 32'(dac_b_o));
    check("reset_led", 32'h0, 32'(led_o));
    read_check("reset_id", addr_of(rp_pkg::REGION_HK, rp_pkg::HK_ID_ADDR), rp_pkg::BOARD_ID);
    finish_test("reset_state");

    // readback of every writable register
    for (int i = 0; i < 8; i++)
    begin
      v = $random(seed);
      bus_write(addr_of(rp_pkg::REGION_HK, rp_pkg::HK_LED_ADDR), v);
      led_m = v & 'hFF;
      read_check("led_reg", addr_of(rp_pkg::REGION_HK, rp_pkg::HK_LED_ADDR), led_m);
      check("led_port", led_m, 32'(led_o));
      set_enable($random(seed));
      read_check("gen_en", addr_of(rp_pkg::REGION_GEN, rp_pkg::GEN_EN_ADDR), en_m);
      set_level(0, $random(seed));
      set_level(1, $random(seed));
      read_check("gen_lvl_a", addr_of(rp_pkg::REGION_GEN, rp_pkg::GEN_LVL_A_ADDR), lvl_m[0]);
      read_check("gen_lvl_b", addr_of(rp_pkg::REGION_GEN, rp_pkg::GEN_LVL_B_ADDR), lvl_m[1]);
      set_sp(0, $random(seed));
      set_sp(1, $random(seed));
      set_kp(0, $random(seed));
      set_kp(1, $random(seed));
      read_check("pid_sp_a", addr_of(rp_pkg::REGION_PID, rp_pkg::PID_SP_A_ADDR), sp_m[0]);
      read_check("pid_sp_b", addr_of(rp_pkg::REGION_PID, rp_pkg::PID_SP_B_ADDR), sp_m[1]);
      read_check("pid_kp_a", addr_of(rp_pkg::REGION_PID, rp_pkg::PID_KP_A_ADDR), kp_m[0]);
      read_check("pid_kp_b", addr_of(rp_pkg::REGION_PID, rp_pkg::PID_KP_B_ADDR), kp_m[1]);
    end
    for (int r = 3; r < 8; r++)         // empty regions
      read_check("unused_region", addr_of(r, rp_pkg::reg_off_t'($random(seed))), 32'h0);
    bus_read(addr_of(rp_pkg::REGION_HK, 20'h10), rd, er);
    check("hk_bad_offset_err", 32'h1, 32'(er));
    check("hk_bad_offset_data", 32'h0, rd);
    bus_read(addr_of(rp_pkg::REGION_GEN, 20'h0C), rd, er);
    check("gen_bad_offset_err", 32'h1, 32'(er));
    bus_read(addr_of(rp_pkg::REGION_PID, 20'h10), rd, er);
    check("pid_bad_offset_err", 32'h1, 32'(er));
    finish_test("register_readback");

    // generator alone, gains at zero
    clear_regs();
    for (int i = 0; i < 8; i++)
    begin
      set_level(0, $random(seed));
      set_level(1, $random(seed));
      set_enable($random(seed));
      set_pins($random(seed), $random(seed));
      wait_cycles(SETTLE);
      check_dacs("dc_level");
    end
    finish_test("dc_generator");

    // controller alone, small gains on odd passes stay out of saturation
    set_enable(0);
    for (int i = 0; i < 8; i++)
    begin
      set_pins($random(seed), $random(seed));
      for (int ch = 0; ch < 2; ch++)
      begin
        set_sp(ch, $random(seed));
        set_kp(ch, (i % 2 == 0) ? $random(seed) : sext($random(seed) & 'hFF, 8));
      end
      wait_cycles(SETTLE);
      check_dacs("p_path");
    end
    finish_test("proportional_path");

    // mode 0 both positive, 1 both negative, 2 opposite signs
    set_enable(3);
    for (int i = 0; i < 6; i++)
    begin
      mode = i % 3;
      for (int ch = 0; ch < 2; ch++)
      begin
        mag = 6000 + ($random(seed) & 'h7FF);
        gs  = (mode == 1 || (mode == 2 && ch == 1)) ? -1 : 1;
        ps  = (mode == 2) ? -gs : gs;
        set_level(ch, gs * mag);
        set_sp(ch, (ps > 0) ? 8191 : -8192);
        set_kp(ch, 1024 + ($random(seed) & 'h3FF));
        pin_m[ch] = to_code((ps > 0) ? -8192 : 8191);   // full-scale error
      end
      set_pins(pin_m[0], pin_m[1]);
      wait_cycles(SETTLE);
      check_dacs("sum_sat");
    end
    finish_test("summation_saturation");

    // dac value fed back in place of the pins
    clear_regs();
    bus_write(addr_of(rp_pkg::REGION_HK, rp_pkg::HK_LOOP_ADDR), 1);
    read_check("loop_reg", addr_of(rp_pkg::REGION_HK, rp_pkg::HK_LOOP_ADDR), 32'h1);
    set_level(0, $random(seed));
    set_level(1, $random(seed));
    set_enable(3);
    wait_cycles(SETTLE);
    check("loop_dac_a", to_code(lvl_m[0]), 32'(dac_a_o));
    check("loop_dac_b", to_code(lvl_m[1]), 32'(dac_b_o));
    // setpoint on the level, closed loop sees zero error at any gain
    for (int ch = 0; ch < 2; ch++)
    begin
      set_sp(ch, lvl_m[ch]);
      set_kp(ch, 1 + ($random(seed) & 'h7F));
    end
    for (int j = 0; j < 6; j++)
    begin
      set_pins($random(seed), $random(seed));   // must have no effect
      wait_cycles(4);
      check("loop_hold_a", to_code(lvl_m[0]), 32'(dac_a_o));
      check("loop_hold_b", to_code(lvl_m[1]), 32'(dac_b_o));
    end
    bus_write(addr_of(rp_pkg::REGION_HK, rp_pkg::HK_LOOP_ADDR), 0);
    finish_test("digital_loop");

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // budget of 200 cycles per test, doubled
  initial
  begin
    #(2 * NUM_TESTS * 200 * CLK_NS);
    $display("the run did not complete within the time limit");
    $display("sim failed");
    $finish;
  end

endmodule

// File: verilog/adc_frontend.sv
// pins must already be synchronous to adc_clk; the loop mux sits after the pin register
`timescale 1ns/1ps

module adc_frontend (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::adc_code_t adc_dat_a_i,    // neg-slope offset binary
  input  rp_pkg::adc_code_t adc_dat_b_i,
  input  logic              digital_loop_i, // take the dac value instead of the pins
  input  rp_pkg::sample_t   loop_a_i,
  input  rp_pkg::sample_t   loop_b_i,
  output rp_pkg::sample_t   adc_a_o,
  output rp_pkg::sample_t   adc_b_o
);

  rp_pkg::sample_t adc_a_q;
  rp_pkg::sample_t adc_b_q;

  ////////////////////////////////////////////////////////////
  // pin register with code conversion
  ////////////////////////////////////////////////////////////

  // keep msb, flip the rest; code 0x1FFF lands on zero
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end
    else
    begin
      adc_a_q <= {adc_dat_a_i[13], ~adc_dat_a_i[12:0]};
      adc_b_q <= {adc_dat_b_i[13], ~adc_dat_b_i[12:0]};
    end
  end

  // digital loop select
  assign adc_a_o = digital_loop_i ? loop_a_i : adc_a_q;
  assign adc_b_o = digital_loop_i ? loop_b_i : adc_b_q;

endmodule

// File: verilog/dac_backend.sv
// no DDR output stage; both channels leave on parallel ports updated every adc_clk
`timescale 1ns/1ps

module dac_backend (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::sample_t   gen_a_i,
  input  rp_pkg::sample_t   gen_b_i,
  input  rp_pkg::sample_t   pid_a_i,
  input  rp_pkg::sample_t   pid_b_i,
  output rp_pkg::adc_code_t dac_a_o,      // neg-slope offset binary
  output rp_pkg::adc_code_t dac_b_o,
  output rp_pkg::sample_t   loop_a_o,     // same register as the dac code
  output rp_pkg::sample_t   loop_b_o
);

  rp_pkg::wide_sum_t sum_a;
  rp_pkg::wide_sum_t sum_b;
  rp_pkg::sample_t   sat_a;
  rp_pkg::sample_t   sat_b;

  ////////////////////////////////////////////////////////////
  // sum and saturate
  ////////////////////////////////////////////////////////////

  // sign extended into 15 bits
  assign sum_a = rp_pkg::wide_sum_t'(gen_a_i) + rp_pkg::wide_sum_t'(pid_a_i);
  assign sum_b = rp_pkg::wide_sum_t'(gen_b_i) + rp_pkg::wide_sum_t'(pid_b_i);

  // top two bits differ -> overflow, clamp toward the sign
  assign sat_a = (^sum_a[14:13]) ? {sum_a[14], {13{~sum_a[14]}}} : sum_a[13:0];
  assign sat_b = (^sum_b[14:13]) ? {sum_b[14], {13{~sum_b[14]}}} : sum_b[13:0];

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      loop_a_o <= '0;
      loop_b_o <= '0;
    end
    else
    begin
      loop_a_o <= sat_a;
      loop_b_o <= sat_b;
    end
  end

  // back to pin code, zero gives 0x1FFF
  assign dac_a_o = {loop_a_o[13], ~loop_a_o[12:0]};
  assign dac_b_o = {loop_b_o[13], ~loop_b_o[12:0]};

endmodule

// File: verilog/dc_generator.sv
// static DC levels only; a level write keeps wdata bits 13..0 and an enable write keeps bits 1..0
`timescale 1ns/1ps

module dc_generator (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::bus_addr_t addr_i,
  input  rp_pkg::bus_data_t wdata_i,
  input  logic              wen_i,
  input  logic              ren_i,
  output rp_pkg::bus_data_t rdata_o,
  output logic              ack_o,
  output logic              err_o,
  output rp_pkg::sample_t   gen_a_o,
  output rp_pkg::sample_t   gen_b_o
);

  rp_pkg::reg_off_t  offs;
  rp_pkg::bus_data_t rd_val;
  logic              hit;
  logic [1:0]        en;                  // per channel enable
  rp_pkg::sample_t   lvl_a;
  rp_pkg::sample_t   lvl_b;

  assign offs = addr_i[rp_pkg::REGION_LSB-1:0];

  always_comb
  begin
    rd_val = '0;
    hit    = 1'b1;
    case (offs)
      rp_pkg::GEN_EN_ADDR:    rd_val = {30'b0, en};
      rp_pkg::GEN_LVL_A_ADDR: rd_val = rp_pkg::bus_data_t'(lvl_a);  // sign extends
      rp_pkg::GEN_LVL_B_ADDR: rd_val = rp_pkg::bus_data_t'(lvl_b);
      default:                hit    = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers, handshake and outputs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      en      <= '0;
      lvl_a   <= '0;
      lvl_b   <= '0;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      gen_a_o <= '0;
      gen_b_o <= '0;
    end
    else
    begin
      if (wen_i && offs == rp_pkg::GEN_EN_ADDR)
        en <= wdata_i[1:0];
      if (wen_i && offs == rp_pkg::GEN_LVL_A_ADDR)
        lvl_a <= wdata_i[13:0];
      if (wen_i && offs == rp_pkg::GEN_LVL_B_ADDR)
        lvl_b <= wdata_i[13:0];
      ack_o   <= wen_i | ren_i;
      err_o   <= (wen_i | ren_i) & ~hit;
      gen_a_o <= en[0] ? lvl_a : '0;     // disabled channel gives zero
      gen_b_o <= en[1] ? lvl_b : '0;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_o <= (ren_i && hit) ? rd_val : '0;
  end

endmodule

// File: verilog/housekeeping.sv
// one-cycle strobes only; the ID register is read-only and a write to it is dropped without error
`timescale 1ns/1ps

module housekeeping (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::bus_addr_t addr_i,
  input  rp_pkg::bus_data_t wdata_i,
  input  logic              wen_i,
  input  logic              ren_i,
  output rp_pkg::bus_data_t rdata_o,      // valid with ack_o
  output logic              ack_o,
  output logic              err_o,
  output logic              digital_loop_o, // dac output back into adc path
  output logic [7:0]        led_o
);

  rp_pkg::reg_off_t  offs;
  rp_pkg::bus_data_t rd_val;
  logic              hit;                 // offset is a known register

  assign offs = addr_i[rp_pkg::REGION_LSB-1:0];

  // register map decode
  always_comb
  begin
    rd_val = '0;
    hit    = 1'b1;
    case (offs)
      rp_pkg::HK_ID_ADDR:   rd_val = rp_pkg::BOARD_ID;
      rp_pkg::HK_LOOP_ADDR: rd_val = {31'b0, digital_loop_o};
      rp_pkg::HK_LED_ADDR:  rd_val = {24'b0, led_o};
      default:              hit    = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // config registers and handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      ack_o          <= 1'b0;
      err_o          <= 1'b0;
    end
    else
    begin
      if (wen_i && offs == rp_pkg::HK_LOOP_ADDR)
        digital_loop_o <= wdata_i[0];
      if (wen_i && offs == rp_pkg::HK_LED_ADDR)
        led_o <= wdata_i[7:0];
      ack_o <= wen_i | ren_i;            // always one cycle after the strobe
      err_o <= (wen_i | ren_i) & ~hit;
    end
  end

  // read data, zero on error or write
  always_ff @(posedge adc_clk)
  begin
    rdata_o <= (ren_i && hit) ? rd_val : '0;
  end

endmodule

// File: verilog/p_controller.sv
// proportional term only; the product is scaled by 2^-KP_SHIFT with truncation and no rounding
`timescale 1ns/1ps

module p_controller #(
  parameter int KP_SHIFT = 8              // right shift of the product
) (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::bus_addr_t addr_i,
  input  rp_pkg::bus_data_t wdata_i,
  input  logic              wen_i,
  input  logic              ren_i,
  output rp_pkg::bus_data_t rdata_o,
  output logic              ack_o,
  output logic              err_o,
  input  rp_pkg::sample_t   adc_a_i,
  input  rp_pkg::sample_t   adc_b_i,
  output rp_pkg::sample_t   pid_a_o,      // two cycles after the input
  output rp_pkg::sample_t   pid_b_o
);

  // error needs a wide_sum_t, times the gain
  localparam int PROD_W = $bits(rp_pkg::wide_sum_t) + $bits(rp_pkg::gain_t);
  localparam rp_pkg::sample_t SAT_MAX = 14'sh1FFF;   // +8191
  localparam rp_pkg::sample_t SAT_MIN = 14'sh2000;   // -8192

  typedef logic signed [PROD_W-1:0] prod_t;

  rp_pkg::reg_off_t  offs;
  rp_pkg::bus_data_t rd_val;
  logic              hit;
  rp_pkg::sample_t   sp   [2];            // setpoints
  rp_pkg::gain_t     kp   [2];            // gains
  rp_pkg::sample_t   din  [2];
  prod_t             prod [2];            // stage 1
  prod_t             shd  [2];
  rp_pkg::sample_t   pid  [2];            // stage 2

  assign offs   = addr_i[rp_pkg::REGION_LSB-1:0];
  assign din[0] = adc_a_i;
  assign din[1] = adc_b_i;

  always_comb
  begin
    rd_val = '0;
    hit    = 1'b1;
    case (offs)
      rp_pkg::PID_SP_A_ADDR: rd_val = rp_pkg::bus_data_t'(sp[0]);  // sign extended
      rp_pkg::PID_SP_B_ADDR: rd_val = rp_pkg::bus_data_t'(sp[1]);
      rp_pkg::PID_KP_A_ADDR: rd_val = rp_pkg::bus_data_t'(kp[0]);
      rp_pkg::PID_KP_B_ADDR: rd_val = rp_pkg::bus_data_t'(kp[1]);
      default:               hit    = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // bus registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      sp[0] <= '0;
      sp[1] <= '0;
      kp[0] <= '0;
      kp[1] <= '0;
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end
    else
    begin
      if (wen_i && offs == rp_pkg::PID_SP_A_ADDR)
        sp[0] <= wdata_i[13:0];
      if (wen_i && offs == rp_pkg::PID_SP_B_ADDR)
        sp[1] <= wdata_i[13:0];
      if (wen_i && offs == rp_pkg::PID_KP_A_ADDR)
        kp[0] <= wdata_i[11:0];
      if (wen_i && offs == rp_pkg::PID_KP_B_ADDR)
        kp[1] <= wdata_i[11:0];
      ack_o <= wen_i | ren_i;
      err_o <= (wen_i | ren_i) & ~hit;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_o <= (ren_i && hit) ? rd_val : '0;
  end

  ////////////////////////////////////////////////////////////
  // multiply, then shift and saturate
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < 2; i++)
      shd[i] = prod[i] >>> KP_SHIFT;      // arithmetic
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < 2; i++)
      begin
        prod[i] <= '0;
        pid[i]  <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        prod[i] <= (prod_t'(sp[i]) - prod_t'(din[i])) * prod_t'(kp[i]);   // full product width
        if (shd[i] > prod_t'(SAT_MAX))
          pid[i] <= SAT_MAX;
        else if (shd[i] < prod_t'(SAT_MIN))
          pid[i] <= SAT_MIN;
        else
          pid[i] <= shd[i][13:0];
      end
    end
  end

  assign pid_a_o = pid[0];
  assign pid_b_o = pid[1];

endmodule

// File: verilog/rp_pkg.sv
// all bus offsets are byte addresses inside a 1 MB region and every write is a full 32-bit word
package rp_pkg;

  ////////////////////////////////////////////////////////////
  // signal path widths
  ////////////////////////////////////////////////////////////

  typedef logic        [13:0] adc_code_t;   // raw pin code, neg-slope offset binary
  typedef logic signed [13:0] sample_t;     // two's complement sample
  typedef logic signed [14:0] wide_sum_t;   // one bit of headroom before saturation
  typedef logic signed [11:0] gain_t;       // proportional gain, integer

  ////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [7:0]  region_sel_t;        // one bit per region

  localparam int REGION_LSB = 20;           // address bits 22..20 pick the region
  localparam int REGION_MSB = 22;

  typedef logic [REGION_LSB-1:0] reg_off_t; // byte offset inside a region

  localparam int REGION_HK  = 0;
  localparam int REGION_GEN = 1;
  localparam int REGION_PID = 2;

  // housekeeping map
  localparam reg_off_t HK_ID_ADDR     = 20'h00;
  localparam reg_off_t HK_LOOP_ADDR   = 20'h04;
  localparam reg_off_t HK_LED_ADDR    = 20'h30;

  // dc generator map
  localparam reg_off_t GEN_EN_ADDR    = 20'h00;   // bit 0 ch a, bit 1 ch b
  localparam reg_off_t GEN_LVL_A_ADDR = 20'h04;
  localparam reg_off_t GEN_LVL_B_ADDR = 20'h08;

  // controller map
  localparam reg_off_t PID_SP_A_ADDR  = 20'h00;
  localparam reg_off_t PID_SP_B_ADDR  = 20'h04;
  localparam reg_off_t PID_KP_A_ADDR  = 20'h08;
  localparam reg_off_t PID_KP_B_ADDR  = 20'h0C;

  localparam bus_data_t BOARD_ID      = 32'h5250_0014;  // returned by the ID register

endpackage

// File: verilog/rp_top.sv
// single clock domain on adc_clk with synchronous active-high reset rst_i; regions 3..7 are empty
`timescale 1ns/1ps

module rp_top #(
  parameter int KP_SHIFT = 8              // passed to the controller
) (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::adc_code_t adc_dat_a_i,
  input  rp_pkg::adc_code_t adc_dat_b_i,
  input  rp_pkg::bus_addr_t sys_addr_i,
  input  rp_pkg::bus_data_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::bus_data_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  output rp_pkg::adc_code_t dac_a_o,
  output rp_pkg::adc_code_t dac_b_o,
  output logic [7:0]        led_o
);

  ////////////////////////////////////////////////////////////
  // bus wiring
  ////////////////////////////////////////////////////////////

  rp_pkg::region_sel_t slot_wen;
  rp_pkg::region_sel_t slot_ren;
  rp_pkg::bus_data_t   hk_rdata;
  rp_pkg::bus_data_t   gen_rdata;
  rp_pkg::bus_data_t   pid_rdata;
  logic                hk_ack;
  logic                gen_ack;
  logic                pid_ack;
  logic                hk_err;
  logic                gen_err;
  logic                pid_err;

  // signal path
  logic                digital_loop;
  rp_pkg::sample_t     adc_a;
  rp_pkg::sample_t     adc_b;
  rp_pkg::sample_t     pid_a;
  rp_pkg::sample_t     pid_b;
  rp_pkg::sample_t     gen_a;
  rp_pkg::sample_t     gen_b;
  rp_pkg::sample_t     loop_a;
  rp_pkg::sample_t     loop_b;

  // slot order is region 7 down to 0, hk=0 gen=1 pid=2
  sys_bus_decoder i_dec (
    .sys_addr_i   (sys_addr_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .slot_wen_o   (slot_wen),
    .slot_ren_o   (slot_ren),
    .slot_rdata_i ({{5{32'h0}}, pid_rdata, gen_rdata, hk_rdata}),
    .slot_ack_i   ({5'b0, pid_ack, gen_ack, hk_ack}),   // decoder fills empty slots
    .slot_err_i   ({5'b0, pid_err, gen_err, hk_err}),
    .sys_rdata_o  (sys_rdata_o),
    .sys_ack_o    (sys_ack_o),
    .sys_err_o    (sys_err_o)
  );

  housekeeping i_hk (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .addr_i         (sys_addr_i),
    .wdata_i        (sys_wdata_i),
    .wen_i          (slot_wen[rp_pkg::REGION_HK]),
    .ren_i          (slot_ren[rp_pkg::REGION_HK]),
    .rdata_o        (hk_rdata),
    .ack_o          (hk_ack),
    .err_o          (hk_err),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  dc_generator i_gen (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .addr_i  (sys_addr_i),
    .wdata_i (sys_wdata_i),
    .wen_i   (slot_wen[rp_pkg::REGION_GEN]),
    .ren_i   (slot_ren[rp_pkg::REGION_GEN]),
    .rdata_o (gen_rdata),
    .ack_o   (gen_ack),
    .err_o   (gen_err),
    .gen_a_o (gen_a),
    .gen_b_o (gen_b)
  );

  p_controller #(
    .KP_SHIFT (KP_SHIFT)
  ) i_pid (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .addr_i  (sys_addr_i),
    .wdata_i (sys_wdata_i),
    .wen_i   (slot_wen[rp_pkg::REGION_PID]),
    .ren_i   (slot_ren[rp_pkg::REGION_PID]),
    .rdata_o (pid_rdata),
    .ack_o   (pid_ack),
    .err_o   (pid_err),
    .adc_a_i (adc_a),
    .adc_b_i (adc_b),
    .pid_a_o (pid_a),
    .pid_b_o (pid_b)
  );

  ////////////////////////////////////////////////////////////
  // adc in, dac out
  ////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (loop_a),
    .loop_b_i       (loop_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  dac_backend i_dac (
    .adc_clk  (adc_clk),
    .rst_i    (rst_i),
    .gen_a_i  (gen_a),
    .gen_b_i  (gen_b),
    .pid_a_i  (pid_a),
    .pid_b_i  (pid_b),
    .dac_a_o  (dac_a_o),
    .dac_b_o  (dac_b_o),
    .loop_a_o (loop_a),       // back to the adc side
    .loop_b_o (loop_b)
  );

endmodule

// File: verilog/sys_bus_decoder.sv
// purely combinational; the master holds the address until ack and unused regions ack at once
`timescale 1ns/1ps

module sys_bus_decoder (
  input  rp_pkg::bus_addr_t       sys_addr_i,     // stable until ack
  input  logic                    sys_wen_i,      // one-cycle write strobe
  input  logic                    sys_ren_i,      // one-cycle read strobe
  output rp_pkg::region_sel_t     slot_wen_o,
  output rp_pkg::region_sel_t     slot_ren_o,
  input  rp_pkg::bus_data_t [7:0] slot_rdata_i,   // indexed by region number
  input  rp_pkg::region_sel_t     slot_ack_i,
  input  rp_pkg::region_sel_t     slot_err_i,
  output rp_pkg::bus_data_t       sys_rdata_o,
  output logic                    sys_ack_o,
  output logic                    sys_err_o
);

  // regions with a slave behind them
  localparam rp_pkg::region_sel_t USED = rp_pkg::region_sel_t'(
    (1 << rp_pkg::REGION_HK) | (1 << rp_pkg::REGION_GEN) | (1 << rp_pkg::REGION_PID));

  logic [rp_pkg::REGION_MSB-rp_pkg::REGION_LSB:0] region;
  rp_pkg::region_sel_t                            sel;

  assign region = sys_addr_i[rp_pkg::REGION_MSB:rp_pkg::REGION_LSB];
  assign sel    = rp_pkg::region_sel_t'(1) << region;   // one-hot

  ////////////////////////////////////////////////////////////
  // strobes out to the slaves
  ////////////////////////////////////////////////////////////

  assign slot_wen_o = sel & {8{sys_wen_i}};
  assign slot_ren_o = sel & {8{sys_ren_i}};

  ////////////////////////////////////////////////////////////
  // answer back to the master
  ////////////////////////////////////////////////////////////

  // empty slots answer with ack high, zero data, no error
  assign sys_rdata_o = |(sel & USED) ? slot_rdata_i[region] : '0;
  assign sys_ack_o   = |(sel & (slot_ack_i | ~USED));
  assign sys_err_o   = |(sel & slot_err_i & USED);

endmodule
